// File: design/manager.sv
// ------------------
// Manager top, WU fetch/decode to OOB downstream
// ------------------
module manager #(
  parameter int WU_DEPTH   = 64,
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               reset,
  // WU load port, only while not busy
  input  logic               load_en,
  input  mgr_pkg::wu_addr_t  load_addr,
  input  mgr_pkg::wu_inst_t  load_data,
  // Run control
  input  logic               start,
  input  mgr_pkg::wu_addr_t  start_addr,
  output logic               busy,
  // Stack bus OOB downstream
  output logic               oob_valid,
  input  logic               oob_ready,
  output mgr_pkg::std_cntl_e oob_cntl,
  output mgr_pkg::oob_type_e oob_type,
  output mgr_pkg::oob_data_t oob_data
);
  import mgr_pkg::*;

  // Fetch / memory
  logic       rd_en;
  wu_addr_t   rd_addr;
  wu_inst_t   rd_data;
  logic       rd_valid;
  logic       fetch_ready;
  // Decode to FIFO
  logic       rec_push;
  oob_tag_t   rec_tag;
  opt_value_t rec_num_lanes;
  opt_value_t rec_stop_cmd;
  opt_value_t rec_simd_cmd;
  logic       credit_return;
  // FIFO to transmitter
  logic       rec_avail;
  logic       rec_pop;
  oob_tag_t   head_tag;
  opt_value_t head_num_lanes;
  opt_value_t head_stop_cmd;
  opt_value_t head_simd_cmd;

  wu_memory #(.WU_DEPTH(WU_DEPTH)) u_wu_memory (
    .clk, .reset, .load_en, .load_addr, .load_data,
    .rd_en, .rd_addr, .rd_data, .rd_valid
  );

  wu_fetch #(.WU_DEPTH(WU_DEPTH)) u_wu_fetch (
    .clk, .reset, .start, .start_addr, .fetch_ready,
    .rd_data, .rd_valid, .rd_en, .rd_addr, .busy
  );

  wu_decode #(.FIFO_DEPTH(FIFO_DEPTH)) u_wu_decode (
    .clk, .reset, .rd_data, .rd_valid, .credit_return, .fetch_ready,
    .rec_push, .rec_tag, .rec_num_lanes, .rec_stop_cmd, .rec_simd_cmd
  );

  oob_cfg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_oob_cfg_fifo (
    .clk, .reset, .rec_push, .rec_tag, .rec_num_lanes, .rec_stop_cmd, .rec_simd_cmd,
    .rec_pop, .rec_avail, .head_tag, .head_num_lanes, .head_stop_cmd, .head_simd_cmd,
    .credit_return
  );

  oob_downstream_cntl u_oob_downstream_cntl (
    .clk, .reset, .rec_avail, .head_tag, .head_num_lanes, .head_stop_cmd,
    .head_simd_cmd, .rec_pop, .oob_valid, .oob_ready, .oob_cntl, .oob_type, .oob_data
  );

endmodule

// File: design/mgr_pkg.sv
// ------------------
// Widths, vector types, enums and instruction field access
// for the WU fetch, decode and OOB downstream path
// ------------------
package mgr_pkg;

  // ------------------
  // Widths
  localparam int WU_ADDR_W   = 6;
  localparam int OPT_VALUE_W = 8;
  localparam int OOB_TAG_W   = 4;
  localparam int OOB_DATA_W  = 8;
  localparam int OPT_SLOTS   = 3;                            // Option slots per instruction
  localparam int OPT_SLOT_W  = 2 + OPT_VALUE_W;              // Type sits above value
  localparam int WU_INST_W   = 3 + OPT_SLOTS * OPT_SLOT_W;   // op, last, then slots

  typedef logic [WU_ADDR_W-1:0]   wu_addr_t;
  typedef logic [OPT_VALUE_W-1:0] opt_value_t;
  typedef logic [OOB_TAG_W-1:0]   oob_tag_t;
  typedef logic [OOB_DATA_W-1:0]  oob_data_t;
  typedef logic [WU_INST_W-1:0]   wu_inst_t;

  // ------------------
  // Encodings
  typedef enum logic [1:0] {INST_NOP, INST_OP, INST_MR, INST_MW} inst_op_e;
  typedef enum logic [1:0] {OPT_NONE, OPT_NUM_LANES, OPT_STOP_CMD, OPT_SIMD_CMD} opt_type_e;
  // OOB word type, also the word order inside a packet
  typedef enum logic [1:0] {OOB_TAG, OOB_NUM_LANES, OOB_STOP_CMD, OOB_SIMD_CMD} oob_type_e;
  typedef enum logic [1:0] {CNTL_SOP, CNTL_MOP, CNTL_EOP, CNTL_SOP_EOP} std_cntl_e;
  typedef enum logic [1:0] {FETCH_IDLE, FETCH_READ, FETCH_DONE} fetch_state_e;
  typedef enum logic [1:0] {OOB_IDLE, OOB_SEND} oob_state_e;

  // ------------------
  // Instruction fields
  function automatic inst_op_e inst_op(wu_inst_t inst);
    return inst_op_e'(inst[WU_INST_W-1 -: 2]);
  endfunction

  function automatic logic inst_last(wu_inst_t inst);
    return inst[WU_INST_W-3];  // Just below the opcode
  endfunction

  // Slot 0 is the most significant slot
  function automatic opt_type_e opt_type(wu_inst_t inst, int slot);
    return opt_type_e'(inst[(OPT_SLOTS - slot) * OPT_SLOT_W - 1 -: 2]);
  endfunction

  function automatic opt_value_t opt_value(wu_inst_t inst, int slot);
    return inst[(OPT_SLOTS - slot) * OPT_SLOT_W - 3 -: OPT_VALUE_W];
  endfunction

endpackage

// File: design/oob_cfg_fifo.sv
// ------------------
// PE config record FIFO, one credit returned per pop
// ------------------
module oob_cfg_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  // From decoder
  input  logic                rec_push,
  input  mgr_pkg::oob_tag_t   rec_tag,
  input  mgr_pkg::opt_value_t rec_num_lanes,
  input  mgr_pkg::opt_value_t rec_stop_cmd,
  input  mgr_pkg::opt_value_t rec_simd_cmd,
  // Head record to transmitter
  input  logic                rec_pop,
  output logic                rec_avail,
  output mgr_pkg::oob_tag_t   head_tag,
  output mgr_pkg::opt_value_t head_num_lanes,
  output mgr_pkg::opt_value_t head_stop_cmd,
  output mgr_pkg::opt_value_t head_simd_cmd,
  output logic                credit_return
);
  import mgr_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int REC_W = OOB_TAG_W + 3 * OPT_VALUE_W;  // tag, lanes, stop, simd

  logic [REC_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rec_push) begin
      mem[wr_ptr] <= {rec_tag, rec_num_lanes, rec_stop_cmd, rec_simd_cmd};
    end
  end

  assign {head_tag, head_num_lanes, head_stop_cmd, head_simd_cmd} = mem[rd_ptr];
  assign rec_avail = (count != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (rec_push) wr_ptr <= next_ptr(wr_ptr);
      if (rec_pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({rec_push, rec_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      credit_return <= rec_pop;  // Back to decoder next cycle
    end
  end

  // Credit scheme keeps both ends in range
  a_no_ovf_unf: assert property (@(posedge clk) disable iff (reset)
    !(rec_push && count == CNT_W'(FIFO_DEPTH)) && !(rec_pop && count == '0));

endmodule

// File: design/oob_downstream_cntl.sv
// ------------------
// OOB downstream transmitter, one record
// out as a four-word stack-bus packet
// ------------------
module oob_downstream_cntl (
  input  logic                 clk,
  input  logic                 reset,
  // Head of record FIFO
  input  logic                 rec_avail,
  input  mgr_pkg::oob_tag_t    head_tag,
  input  mgr_pkg::opt_value_t  head_num_lanes,
  input  mgr_pkg::opt_value_t  head_stop_cmd,
  input  mgr_pkg::opt_value_t  head_simd_cmd,
  output logic                 rec_pop,
  // Stack bus OOB downstream
  output logic                 oob_valid,
  input  logic                 oob_ready,
  output mgr_pkg::std_cntl_e   oob_cntl,
  output mgr_pkg::oob_type_e   oob_type,
  output mgr_pkg::oob_data_t   oob_data
);
  import mgr_pkg::*;

  oob_state_e state;
  logic [1:0] word_idx;   // Word within packet
  logic       last_word;
  oob_tag_t   hold_tag;   // Record being sent
  opt_value_t hold_lanes;
  opt_value_t hold_stop;
  opt_value_t hold_simd;

  assign rec_pop   = (state == OOB_IDLE) && rec_avail;
  assign oob_valid = (state == OOB_SEND);
  assign last_word = (word_idx == 2'd3);
  assign oob_type  = oob_type_e'(word_idx);  // TAG, lanes, stop, simd

  // ------------------
  // Word mux
  always_comb begin
    case (word_idx)
      2'd0: begin
        oob_cntl = CNTL_SOP;
        oob_data = oob_data_t'(hold_tag);  // Zero-extended
      end
      2'd1: begin
        oob_cntl = CNTL_MOP;
        oob_data = hold_lanes;
      end
      2'd2: begin
        oob_cntl = CNTL_MOP;
        oob_data = hold_stop;
      end
      default: begin
        oob_cntl = CNTL_EOP;
        oob_data = hold_simd;
      end
    endcase
  end

  // Holding register, loaded on pop
  always_ff @(posedge clk) begin
    if (rec_pop) begin
      hold_tag   <= head_tag;
      hold_lanes <= head_num_lanes;
      hold_stop  <= head_stop_cmd;
      hold_simd  <= head_simd_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= OOB_IDLE;
      word_idx <= '0;
    end else begin
      case (state)
        OOB_IDLE: begin
          if (rec_avail) begin
            state    <= OOB_SEND;
            word_idx <= '0;
          end
        end
        OOB_SEND: begin
          if (oob_ready) begin
            word_idx <= word_idx + 1'b1;  // Wraps to 0 after EOP
            if (last_word) state <= OOB_IDLE;
          end
        end
        default: state <= OOB_IDLE;
      endcase
    end
  end

  // Stalled word held until accepted
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    oob_valid && !oob_ready |=>
      oob_valid && $stable(oob_type) && $stable(oob_cntl) && $stable(oob_data));

endmodule

// File: design/wu_decode.sv
// ------------------
// WU decoder, OP instructions to tagged PE config records
// with the credit side of the record FIFO link
// ------------------
module wu_decode #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  // From WU memory
  input  mgr_pkg::wu_inst_t   rd_data,
  input  logic                rd_valid,
  // Credit link
  input  logic                credit_return,  // One per popped record
  output logic                fetch_ready,
  // Record out
  output logic                rec_push,
  output mgr_pkg::oob_tag_t   rec_tag,
  output mgr_pkg::opt_value_t rec_num_lanes,
  output mgr_pkg::opt_value_t rec_stop_cmd,
  output mgr_pkg::opt_value_t rec_simd_cmd
);
  import mgr_pkg::*;

  localparam int                CRED_W   = $clog2(FIFO_DEPTH + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(FIFO_DEPTH);

  logic [CRED_W-1:0] credits;    // Free FIFO slots not yet spent
  logic [CRED_W-1:0] in_flight;  // Record waiting to be charged
  oob_tag_t          tag;        // Next tag, wraps at 16
  logic              is_op;
  opt_value_t        lanes_d;
  opt_value_t        stop_d;
  opt_value_t        simd_d;

  // NOP, MR and MW are dropped here
  assign is_op = rd_valid && (inst_op(rd_data) == INST_OP);

  // ------------------
  // Option scan
  // Later slot overrides, absent fields stay zero
  always_comb begin
    lanes_d = '0;
    stop_d  = '0;
    simd_d  = '0;
    for (int s = 0; s < OPT_SLOTS; s++) begin
      case (opt_type(rd_data, s))
        OPT_NUM_LANES: lanes_d = opt_value(rd_data, s);
        OPT_STOP_CMD:  stop_d  = opt_value(rd_data, s);
        OPT_SIMD_CMD:  simd_d  = opt_value(rd_data, s);
        default: ;  // Empty slot
      endcase
    end
  end

  // Record payload, captured with the current tag
  always_ff @(posedge clk) begin
    if (is_op) begin
      rec_tag       <= tag;
      rec_num_lanes <= lanes_d;
      rec_stop_cmd  <= stop_d;
      rec_simd_cmd  <= simd_d;
    end
  end

  // ------------------
  // Push, tag and credits
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_push <= 1'b0;
      tag      <= '0;
      credits  <= CRED_MAX;
    end else begin
      rec_push <= is_op;  // Push one cycle after rd_valid
      if (is_op) begin
        tag <= tag + 1'b1;
      end
      case ({rec_push, credit_return})
        2'b10:   credits <= credits - 1'b1;  // Spent on push
        2'b01:   credits <= credits + 1'b1;  // Slot freed downstream
        default: ;
      endcase
    end
  end

  // Pushing record still counts against the credits this cycle
  assign in_flight   = {{(CRED_W-1){1'b0}}, rec_push};
  assign fetch_ready = (credits > in_flight);

  // Credits bounded by the FIFO and never overdrawn
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    (credits <= CRED_MAX) && !(rec_push && credits == '0));

endmodule

// File: design/wu_fetch.sv
// ------------------
// WU fetch FSM issuing sequential reads from the
// start address up to the last instruction
// ------------------
module wu_fetch #(
  parameter int WU_DEPTH = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  mgr_pkg::wu_addr_t start_addr,
  input  logic              fetch_ready,  // Room downstream for one more
  input  mgr_pkg::wu_inst_t rd_data,
  input  logic              rd_valid,
  output logic              rd_en,
  output mgr_pkg::wu_addr_t rd_addr,
  output logic              busy
);
  import mgr_pkg::*;

  localparam wu_addr_t LAST_ADDR = wu_addr_t'(WU_DEPTH - 1);  // Wrap point

  fetch_state_e state;
  logic         rtn_pend;  // Read issued and data not back yet
  logic         last_rtn;  // Final instruction just came back

  assign last_rtn = rd_valid && inst_last(rd_data);
  assign busy     = (state == FETCH_READ);
  // Next read only after the previous one has returned
  assign rd_en    = busy && !rtn_pend && fetch_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= FETCH_IDLE;
      rtn_pend <= 1'b0;
      rd_addr  <= '0;
    end else begin
      case (state)
        FETCH_IDLE, FETCH_DONE: begin
          if (start) begin
            state <= FETCH_READ;
          end
        end
        FETCH_READ: begin
          if (last_rtn) begin
            state <= FETCH_DONE;  // WU complete so wait for next start
          end
        end
        default: state <= FETCH_IDLE;
      endcase

      if (rd_en) begin
        rtn_pend <= 1'b1;
      end else if (rd_valid) begin
        rtn_pend <= 1'b0;
      end

      if (start && !busy) begin
        rd_addr <= start_addr;                                     // Start ignored while busy
      end else if (rd_en) begin
        rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;  // Wrap after last entry
      end
    end
  end

  // ------------------
  // Checks
  // No read outstanding or returning outside READ
  a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
    (state != FETCH_READ) |-> !rtn_pend && !rd_valid);

  // Memory answers next cycle and never two reads outstanding
  a_one_inflight: assert property (@(posedge clk) disable iff (reset)
    rd_en |=> rd_valid && !rd_en);

endmodule

// File: design/wu_memory.sv
// ------------------
// WU instruction store, load write port
// and one-cycle registered read port
// ------------------
module wu_memory #(
  parameter int WU_DEPTH = 64
) (
  input  logic              clk,
  input  logic              reset,
  // Load port
  input  logic              load_en,
  input  mgr_pkg::wu_addr_t load_addr,
  input  mgr_pkg::wu_inst_t load_data,
  // Fetch read port
  input  logic              rd_en,
  input  mgr_pkg::wu_addr_t rd_addr,
  output mgr_pkg::wu_inst_t rd_data,
  output logic              rd_valid
);
  import mgr_pkg::*;

  wu_inst_t mem [WU_DEPTH];  // Instruction array

  // Depth has to fit the address
  if (WU_DEPTH > (1 << WU_ADDR_W)) begin : g_depth_chk
    $error("WU_DEPTH exceeds the WU address range");
  end

  // ------------------
  // Storage
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // One entry per cycle
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];      // Data lands with rd_valid
    end
  end

  // Read strobe, one cycle behind rd_en
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

// File: manager.f
+incdir+include
design/mgr_pkg.sv
design/wu_memory.sv
design/wu_fetch.sv
design/wu_decode.sv
design/oob_cfg_fifo.sv
design/oob_downstream_cntl.sv
design/manager.sv
sim/manager_tb.sv

// File: include/manager_ref.svh
// ------------------
// Reference model building expected OOB words from a WU image
// ------------------
`ifndef MANAGER_REF_SVH
`define MANAGER_REF_SVH

// Expected word packed as {type, cntl, data}
typedef logic [3 + mgr_pkg::OOB_DATA_W:0] ref_word_t;

function automatic ref_word_t ref_word(mgr_pkg::oob_type_e typ, mgr_pkg::std_cntl_e cntl,
                                       mgr_pkg::oob_data_t data);
  return {typ, cntl, data};
endfunction

// Walk from start_addr to the last bit with wrap at depth
// Layout from the top is op[32:31], last[30], then three 10-bit slots of type over value
function automatic void manager_ref_build(
  input  mgr_pkg::wu_inst_t image [2**mgr_pkg::WU_ADDR_W],
  input  mgr_pkg::wu_addr_t start_addr,
  input  int                depth,
  input  mgr_pkg::oob_tag_t tag_in,
  output ref_word_t         words [$],
  output mgr_pkg::oob_tag_t tag_out
);
  mgr_pkg::wu_addr_t   addr;
  mgr_pkg::wu_inst_t   inst;
  mgr_pkg::oob_tag_t   tag;
  mgr_pkg::opt_value_t field [4];  // Value per option type with NONE unused
  int                  hi;

  words = {};
  addr  = start_addr;
  tag   = tag_in;
  for (int n = 0; n < depth; n++) begin  // At most one pass over memory
    inst = image[addr];
    if (mgr_pkg::inst_op_e'(inst[32:31]) == mgr_pkg::INST_OP) begin
      foreach (field[t]) field[t] = '0;  // Missing options go out as zero
      for (int s = 0; s < 3; s++) begin
        hi = 29 - 10 * s;                           // Slot 0 highest
        field[inst[hi -: 2]] = inst[hi - 2 -: 8];  // Later slot wins
      end
      words.push_back(ref_word(mgr_pkg::OOB_TAG, mgr_pkg::CNTL_SOP, mgr_pkg::oob_data_t'(tag)));
      words.push_back(ref_word(mgr_pkg::OOB_NUM_LANES, mgr_pkg::CNTL_MOP,
                               field[mgr_pkg::OPT_NUM_LANES]));
      words.push_back(ref_word(mgr_pkg::OOB_STOP_CMD, mgr_pkg::CNTL_MOP,
                               field[mgr_pkg::OPT_STOP_CMD]));
      words.push_back(ref_word(mgr_pkg::OOB_SIMD_CMD, mgr_pkg::CNTL_EOP,
                               field[mgr_pkg::OPT_SIMD_CMD]));
      tag = tag + 1'b1;  // Wraps past 15
    end
    if (inst[30]) break;  // Last instruction
    addr = (int'(addr) == depth - 1) ? '0 : addr + 1'b1;
  end
  tag_out = tag;
endfunction

`endif

// File: sim/manager_tb.sv
// --------------------
// Manager testbench with clock, reset, WU stimulus,
// OOB comparator, watchdog and five tests
// --------------------
`include "manager_ref.svh"

module manager_tb;
  import mgr_pkg::*;

  localparam int WU_DEPTH     = 64;
  localparam int FIFO_DEPTH   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 400;  // Words left after busy falls
  // Instructions walked per test
  localparam int N_T1 = 1;
  localparam int N_T2 = 8;
  localparam int N_T3 = 40;
  localparam int N_T4 = 6;
  localparam int N_T5 = 22;  // Two WUs of 12 and 10
  localparam int WATCHDOG_CYCLES = 20 * (N_T1 + N_T2 + N_T3 + N_T4 + N_T5) + 1000;

  logic      clk;
  logic      reset;
  logic      load_en;
  wu_addr_t  load_addr;
  wu_inst_t  load_data;
  logic      start;
  wu_addr_t  start_addr;
  logic      busy;
  logic      oob_valid;
  logic      oob_ready;
  std_cntl_e oob_cntl;
  oob_type_e oob_type;
  oob_data_t oob_data;

  wu_inst_t  image [2**WU_ADDR_W];  // Mirror of WU memory
  ref_word_t exp_q [$];             // Words still owed by the DUT
  oob_tag_t  exp_tag;               // Tag the next packet should carry
  logic      rand_ready;            // Random back-pressure on/off
  int        err_count;
  int        word_count;
  int        tests_failed;

  manager #(.WU_DEPTH(WU_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
    .clk, .reset, .load_en, .load_addr, .load_data, .start, .start_addr,
    .busy, .oob_valid, .oob_ready, .oob_cntl, .oob_type, .oob_data
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Helpers
  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      err_count++;
    end
  endtask

  // Advance one cycle with inputs changed on the falling edge
  task automatic next_cycle();
    @(negedge clk);
    oob_ready = rand_ready ? ($urandom_range(9) < 3) : 1'b1;  // About 30% high
  endtask

  function automatic wu_inst_t make_inst(inst_op_e op, logic last,
                                         opt_type_e t0, opt_value_t v0,
                                         opt_type_e t1, opt_value_t v1,
                                         opt_type_e t2, opt_value_t v2);
    return {op, last, t0, v0, t1, v1, t2, v2};  // Slot 0 on top
  endfunction

  function automatic wu_inst_t random_inst(logic last, logic op_only);
    inst_op_e op;
    op = (op_only || $urandom_range(3) != 0) ? INST_OP : inst_op_e'($urandom_range(3));
    return make_inst(op, last,
                     opt_type_e'($urandom_range(3)), opt_value_t'($urandom),
                     opt_type_e'($urandom_range(3)), opt_value_t'($urandom),
                     opt_type_e'($urandom_range(3)), opt_value_t'($urandom));
  endfunction

  // NOPs with the address spread over every option bit
  task automatic fill_image();
    for (int a = 0; a < 2**WU_ADDR_W; a++) begin
      image[a] = {INST_NOP, 1'b0, {5{wu_addr_t'(a)}}};
    end
  endtask

  task automatic load_image();
    for (int a = 0; a < WU_DEPTH; a++) begin
      load_en   = 1'b1;
      load_addr = wu_addr_t'(a);
      load_data = image[a];
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  // Start one WU and wait for busy low plus every expected word
  task automatic run_wu(wu_addr_t addr, int n_instr, logic stray);
    ref_word_t words [$];
    oob_tag_t  next_tag;
    int        cycles;
    manager_ref_build(image, addr, WU_DEPTH, exp_tag, words, next_tag);
    foreach (words[i]) exp_q.push_back(words[i]);
    exp_tag    = next_tag;
    start      = 1'b1;
    start_addr = addr;
    next_cycle();
    start = 1'b0;
    if (!busy) begin
      $display("ERROR: busy did not rise after start at address %0d", addr);
      err_count++;
    end
    cycles = 0;
    while (busy && cycles < 20 * n_instr + 100) begin
      if (stray && cycles == 3) begin  // Stray start while busy
        start      = 1'b1;
        start_addr = addr + 6'd5;
      end else begin
        start = 1'b0;
      end
      next_cycle();
      cycles++;
    end
    start = 1'b0;
    if (busy) begin
      $display("ERROR: busy still high %0d cycles after start", cycles);
      err_count++;
    end
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
      next_cycle();
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: busy low with %0d expected words still pending after drain limit",
               exp_q.size());
      err_count++;
      exp_q.delete();  // Next test starts clean
    end
  endtask

  task automatic report_test(int num, string name, int err_before, int words_before);
    int errs;
    errs = err_count - err_before;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %0d packets, %0d errors", num, name,
             (word_count - words_before) / 4, errs);
  endtask

  // --------------------
  // Comparator pops one expected word per OOB transfer
  always @(posedge clk) begin
    ref_word_t w;
    if (!reset && oob_valid && oob_ready) begin
      word_count++;
      if (exp_q.size() == 0) begin
        $display("ERROR: OOB word sent with nothing expected, type %h data %h",
                 oob_type, oob_data);
        err_count++;
      end else begin
        w = exp_q.pop_front();
        check_value("oob_type", 32'(oob_type), 32'(w[OOB_DATA_W+3 -: 2]));
        check_value("oob_cntl", 32'(oob_cntl), 32'(w[OOB_DATA_W+1 -: 2]));
        check_value("oob_data", 32'(oob_data), 32'(w[OOB_DATA_W-1:0]));
      end
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------
  // Stimulus
  initial begin
    int       e0;
    int       w0;
    wu_addr_t a;
    void'($urandom(32'h4c738bca));
    reset        = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    start        = 1'b0;
    start_addr   = '0;
    oob_ready    = 1'b1;
    rand_ready   = 1'b0;
    exp_tag      = '0;
    err_count    = 0;
    word_count   = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    next_cycle();

    // Test 1 with one OP and all three options
    e0 = err_count;
    w0 = word_count;
    fill_image();
    image[0] = make_inst(INST_OP, 1'b1, OPT_NUM_LANES, 8'h10, OPT_STOP_CMD, 8'ha5,
                         OPT_SIMD_CMD, 8'h3c);
    load_image();
    run_wu(6'd0, N_T1, 1'b0);
    report_test(1, "single OP", e0, w0);

    // Test 2 mixes opcodes with missing and duplicate options
    e0 = err_count;
    w0 = word_count;
    fill_image();
    image[8]  = make_inst(INST_NOP, 1'b0, OPT_NUM_LANES, 8'h11, OPT_NONE, 8'h00,
                          OPT_SIMD_CMD, 8'h12);
    image[9]  = make_inst(INST_OP, 1'b0, OPT_NUM_LANES, 8'h04, OPT_STOP_CMD, 8'h11,
                          OPT_SIMD_CMD, 8'h22);
    image[10] = make_inst(INST_MR, 1'b0, OPT_STOP_CMD, 8'h33, OPT_NONE, 8'h00,
                          OPT_NONE, 8'h00);
    image[11] = make_inst(INST_OP, 1'b0, OPT_NONE, 8'hee, OPT_STOP_CMD, 8'h77,
                          OPT_NONE, 8'hdd);  // Lanes and SIMD absent
    image[12] = make_inst(INST_MW, 1'b0, OPT_NUM_LANES, 8'h55, OPT_STOP_CMD, 8'h66,
                          OPT_SIMD_CMD, 8'h77);
    image[13] = make_inst(INST_OP, 1'b0, OPT_NUM_LANES, 8'h01, OPT_SIMD_CMD, 8'h05,
                          OPT_NUM_LANES, 8'h02);  // Later lanes wins
    image[14] = make_inst(INST_OP, 1'b0, OPT_NONE, 8'h00, OPT_NONE, 8'h00,
                          OPT_NONE, 8'h00);
    image[15] = make_inst(INST_MW, 1'b1, OPT_SIMD_CMD, 8'h99, OPT_NONE, 8'h00,
                          OPT_NONE, 8'h00);  // Non-OP last
    load_image();
    run_wu(6'd8, N_T2, 1'b0);
    report_test(2, "mixed opcodes", e0, w0);

    // Test 3 runs a long random WU under random back-pressure
    e0 = err_count;
    w0 = word_count;
    fill_image();
    for (int i = 0; i < N_T3; i++) begin
      image[16 + i] = random_inst(i == N_T3 - 1, 1'b0);
    end
    load_image();
    rand_ready = 1'b1;
    run_wu(6'd16, N_T3, 1'b0);
    rand_ready = 1'b0;
    report_test(3, "random back-pressure", e0, w0);

    // Test 4 wraps from the top of memory to 0 with one OP past last
    e0 = err_count;
    w0 = word_count;
    fill_image();
    for (int i = 0; i <= N_T4; i++) begin
      a = wu_addr_t'(60 + i);
      image[a] = make_inst(INST_OP, i == N_T4 - 1, OPT_NUM_LANES, 8'(i + 1),
                           OPT_STOP_CMD, 8'(8'h40 + i), OPT_SIMD_CMD, 8'(8'h80 + i));
    end
    load_image();
    run_wu(6'd60, N_T4, 1'b0);
    report_test(4, "address wrap", e0, w0);

    // Test 5 runs two WUs back to back and the tag wraps past 15
    e0 = err_count;
    w0 = word_count;
    fill_image();
    for (int i = 0; i < 12; i++) begin
      image[20 + i] = random_inst(i == 11, 1'b1);
    end
    for (int i = 0; i < 10; i++) begin
      image[40 + i] = random_inst(i == 9, 1'b1);
    end
    load_image();
    run_wu(6'd20, 12, 1'b1);
    run_wu(6'd40, 10, 1'b0);
    report_test(5, "second start and tag wrap", e0, w0);

    $display("tests 5, failed %0d, OOB words %0d, errors %0d",
             tests_failed, word_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
